//--- verilog/nlc_fix_pkg.sv
package nlc_fix_pkg;

  // Arithmetic word, signed Q16.16
  localparam int FIX_W = 32;
  localparam int FRAC_BITS = 16;

  // ADC sample and corrected output width
  localparam int SAMPLE_W = 21;

  typedef logic signed [FIX_W-1:0] fix_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

//--- verilog/nlc_chan_pkg.sv
package nlc_chan_pkg;

  // Highest polynomial coefficient
  localparam int POLY_ORDER = 5;

  // One channel's constants, coeff[5] is the leading term
  typedef struct packed {
    nlc_fix_pkg::sample_t                     sample;
    nlc_fix_pkg::fix_t                        neg_mean;
    nlc_fix_pkg::fix_t                        recip_stdev;
    nlc_fix_pkg::fix_t [POLY_ORDER:0]         coeff;
  } chan_params_t;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_MUL = 1'b1
  } arith_op_t;

  // Requester tags on the shared unit
  localparam logic TAG_NORM = 1'b0;
  localparam logic TAG_POLY = 1'b1;

  typedef struct packed {
    arith_op_t         op;
    nlc_fix_pkg::fix_t a;
    nlc_fix_pkg::fix_t b;
    logic              tag;
  } arith_req_t;

  typedef struct packed {
    nlc_fix_pkg::fix_t result;
    logic              tag;
  } arith_rsp_t;

endpackage

//--- verilog/nlc_param_store.sv
module nlc_param_store #(
  parameter int NUM_CH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load,
  input  logic [$clog2(NUM_CH)-1:0]   load_chan,
  input  nlc_chan_pkg::chan_params_t  load_params,
  input  logic [$clog2(NUM_CH)-1:0]   norm_chan,
  output nlc_chan_pkg::chan_params_t  norm_params,
  input  logic [$clog2(NUM_CH)-1:0]   poly_chan,
  output nlc_chan_pkg::chan_params_t  poly_params
);
  import nlc_chan_pkg::*;

  chan_params_t mem [NUM_CH];

  // One record per load strobe, loads during reset are dropped
  always_ff @(posedge clk) begin
    if (load && !rst) begin
      mem[load_chan] <= load_params;
    end
  end

  // Independent read ports for the two engines
  assign norm_params = mem[norm_chan];
  assign poly_params = mem[poly_chan];

endmodule

//--- verilog/nlc_arith_unit.sv
module nlc_arith_unit #(
  parameter int ARITH_LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  nlc_chan_pkg::arith_req_t req,
  output logic                     rsp_valid,
  output nlc_chan_pkg::arith_rsp_t rsp
);
  import nlc_fix_pkg::*;
  import nlc_chan_pkg::*;

  logic signed [2*FIX_W-1:0] prod;
  fix_t                      result;
  logic [ARITH_LATENCY-1:0]  vld_q;
  arith_rsp_t                pipe_q [ARITH_LATENCY];

  always_comb begin
    prod = req.a * req.b;
    if (req.op == OP_MUL) begin
      // Drop fraction bits, keep low word
      result = prod[FRAC_BITS +: FIX_W];
    end else begin
      result = req.a + req.b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= req_valid;
      for (int i = 1; i < ARITH_LATENCY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_q[0].result <= result;
    pipe_q[0].tag    <= req.tag;
    for (int i = 1; i < ARITH_LATENCY; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

  assign rsp_valid = vld_q[ARITH_LATENCY-1];
  assign rsp       = pipe_q[ARITH_LATENCY-1];

endmodule

//--- verilog/nlc_arbiter.sv
module nlc_arbiter (
  input  logic                     norm_req_valid,
  input  nlc_chan_pkg::arith_req_t norm_req,
  output logic                     norm_gnt,
  output logic                     norm_rsp_valid,
  input  logic                     poly_req_valid,
  input  nlc_chan_pkg::arith_req_t poly_req,
  output logic                     poly_gnt,
  output logic                     poly_rsp_valid,
  output nlc_fix_pkg::fix_t        rsp_result,
  output logic                     unit_req_valid,
  output nlc_chan_pkg::arith_req_t unit_req,
  input  logic                     unit_rsp_valid,
  input  nlc_chan_pkg::arith_rsp_t unit_rsp
);
  import nlc_chan_pkg::*;

  // Poly engine has priority, it holds the longer chain
  always_comb begin
    poly_gnt       = poly_req_valid;
    norm_gnt       = norm_req_valid && !poly_req_valid;
    unit_req_valid = poly_req_valid || norm_req_valid;
    if (poly_req_valid) begin
      unit_req     = poly_req;
      unit_req.tag = TAG_POLY;
    end else begin
      unit_req     = norm_req;
      unit_req.tag = TAG_NORM;
    end
  end

  // Return path steered by tag
  always_comb begin
    norm_rsp_valid = unit_rsp_valid && (unit_rsp.tag == TAG_NORM);
    poly_rsp_valid = unit_rsp_valid && (unit_rsp.tag == TAG_POLY);
    rsp_result     = unit_rsp.result;
  end

endmodule

//--- verilog/nlc_normalizer.sv
module nlc_normalizer #(
  parameter int NUM_CH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  output logic [$clog2(NUM_CH)-1:0]   chan,
  input  nlc_chan_pkg::chan_params_t  params,
  output logic                        req_valid,
  output nlc_chan_pkg::arith_req_t    req,
  input  logic                        gnt,
  input  logic                        rsp_valid,
  input  nlc_fix_pkg::fix_t           rsp_result,
  output logic                        norm_valid,
  output logic [$clog2(NUM_CH)-1:0]   norm_chan,
  output nlc_fix_pkg::fix_t           norm_value
);
  import nlc_fix_pkg::*;
  import nlc_chan_pkg::*;

  localparam int CH_W = $clog2(NUM_CH);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADD_REQ,
    S_ADD_WAIT,
    S_MUL_REQ,
    S_MUL_WAIT
  } state_t;

  state_t          state;
  logic [CH_W-1:0] chan_q;
  logic            restart_q;
  logic            restart;
  fix_t            sum_q;
  fix_t            sample_fix;

  assign chan    = chan_q;
  assign restart = restart_q || start;

  // Sample into Q16.16
  assign sample_fix = fix_t'(params.sample) <<< FRAC_BITS;

  always_comb begin
    req_valid = (state == S_ADD_REQ) || (state == S_MUL_REQ);
    req.tag   = 1'b0;
    if (state == S_MUL_REQ) begin
      req.op = OP_MUL;
      req.a  = sum_q;
      req.b  = params.recip_stdev;
    end else begin
      req.op = OP_ADD;
      req.a  = sample_fix;
      req.b  = params.neg_mean;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      chan_q     <= '0;
      restart_q  <= 1'b0;
      norm_valid <= 1'b0;
    end else begin
      norm_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            chan_q <= '0;
            state  <= S_ADD_REQ;
          end
        end
        S_ADD_REQ, S_MUL_REQ: begin
          // Request stays up until granted, restart comes later
          if (start) begin
            restart_q <= 1'b1;
          end
          if (gnt) begin
            state <= (state == S_ADD_REQ) ? S_ADD_WAIT : S_MUL_WAIT;
          end
        end
        default: begin
          if (rsp_valid && restart) begin
            // Outstanding result is dropped
            restart_q <= 1'b0;
            chan_q    <= '0;
            state     <= S_ADD_REQ;
          end else if (rsp_valid && state == S_ADD_WAIT) begin
            state <= S_MUL_REQ;
          end else if (rsp_valid) begin
            norm_valid <= 1'b1;
            if (chan_q == CH_W'(NUM_CH - 1)) begin
              state <= S_IDLE;
            end else begin
              chan_q <= chan_q + 1'b1;
              state  <= S_ADD_REQ;
            end
          end else if (start) begin
            restart_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid && state == S_ADD_WAIT) begin
      sum_q <= rsp_result;
    end
    if (rsp_valid && state == S_MUL_WAIT) begin
      norm_chan  <= chan_q;
      norm_value <= rsp_result;
    end
  end

endmodule

//--- verilog/nlc_poly_engine.sv
module nlc_poly_engine #(
  parameter int NUM_CH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic                        norm_valid,
  input  logic [$clog2(NUM_CH)-1:0]   norm_chan,
  input  nlc_fix_pkg::fix_t           norm_value,
  output logic [$clog2(NUM_CH)-1:0]   chan,
  input  nlc_chan_pkg::chan_params_t  params,
  output logic                        req_valid,
  output nlc_chan_pkg::arith_req_t    req,
  input  logic                        gnt,
  input  logic                        rsp_valid,
  input  nlc_fix_pkg::fix_t           rsp_result,
  output logic                        out_valid,
  output logic [$clog2(NUM_CH)-1:0]   out_chan,
  output nlc_fix_pkg::sample_t        out_value,
  output logic                        done
);
  import nlc_fix_pkg::*;
  import nlc_chan_pkg::*;

  localparam int CH_W = $clog2(NUM_CH);
  localparam int K_W  = $clog2(POLY_ORDER + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_RDY,
    S_MUL_REQ,
    S_MUL_WAIT,
    S_ADD_REQ,
    S_ADD_WAIT
  } state_t;

  state_t            state;
  logic [CH_W-1:0]   chan_q;
  logic [K_W-1:0]    k_q;
  logic [NUM_CH-1:0] ready_q;
  fix_t              acc_q;
  fix_t              norm_mem [NUM_CH];

  assign chan = chan_q;

  // Horner step: acc * x, then acc + coeff[k]
  always_comb begin
    req_valid = (state == S_MUL_REQ) || (state == S_ADD_REQ);
    req.op    = (state == S_MUL_REQ) ? OP_MUL : OP_ADD;
    req.a     = acc_q;
    req.b     = (state == S_MUL_REQ) ? norm_mem[chan_q] : params.coeff[k_q];
    req.tag   = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      chan_q    <= '0;
      k_q       <= '0;
      ready_q   <= '0;
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (norm_valid) begin
        ready_q[norm_chan] <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (start) begin
            ready_q <= '0;
            done    <= 1'b0;
            chan_q  <= '0;
            state   <= S_WAIT_RDY;
          end
        end
        S_WAIT_RDY: begin
          if (ready_q[chan_q]) begin
            k_q   <= K_W'(POLY_ORDER - 1);
            state <= S_MUL_REQ;
          end
        end
        S_MUL_REQ: begin
          if (gnt) begin
            state <= S_MUL_WAIT;
          end
        end
        S_MUL_WAIT: begin
          if (rsp_valid) begin
            state <= S_ADD_REQ;
          end
        end
        S_ADD_REQ: begin
          if (gnt) begin
            state <= S_ADD_WAIT;
          end
        end
        default: begin
          if (rsp_valid && k_q != '0) begin
            k_q   <= k_q - 1'b1;
            state <= S_MUL_REQ;
          end else if (rsp_valid) begin
            out_valid <= 1'b1;
            if (chan_q == CH_W'(NUM_CH - 1)) begin
              done  <= 1'b1;
              state <= S_IDLE;
            end else begin
              chan_q <= chan_q + 1'b1;
              state  <= S_WAIT_RDY;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (norm_valid) begin
      norm_mem[norm_chan] <= norm_value;
    end
    if (state == S_WAIT_RDY) begin
      acc_q <= params.coeff[POLY_ORDER];
    end else if (rsp_valid) begin
      acc_q <= rsp_result;
    end
    // Floor back to an integer sample
    if (rsp_valid && state == S_ADD_WAIT && k_q == '0) begin
      out_chan  <= chan_q;
      out_value <= sample_t'(rsp_result >>> FRAC_BITS);
    end
  end

endmodule

//--- verilog/nlc_controller.sv
module nlc_controller #(
  parameter int NUM_CH        = 16,
  parameter int ARITH_LATENCY = 2
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load,
  input  logic [$clog2(NUM_CH)-1:0]   load_chan,
  input  nlc_chan_pkg::chan_params_t  load_params,
  input  logic                        start,
  output logic                        out_valid,
  output logic [$clog2(NUM_CH)-1:0]   out_chan,
  output nlc_fix_pkg::sample_t        out_value,
  output logic                        done
);
  import nlc_fix_pkg::*;
  import nlc_chan_pkg::*;

  localparam int CH_W = $clog2(NUM_CH);

  // Store read ports
  logic [CH_W-1:0] norm_rd_chan;
  logic [CH_W-1:0] poly_rd_chan;
  chan_params_t    norm_params;
  chan_params_t    poly_params;

  // Requester side of the arbiter
  logic            norm_req_valid;
  arith_req_t      norm_req;
  logic            norm_gnt;
  logic            norm_rsp_valid;
  logic            poly_req_valid;
  arith_req_t      poly_req;
  logic            poly_gnt;
  logic            poly_rsp_valid;
  fix_t            rsp_result;

  // Shared unit side
  logic            unit_req_valid;
  arith_req_t      unit_req;
  logic            unit_rsp_valid;
  arith_rsp_t      unit_rsp;

  // Normalized values into the poly engine
  logic            norm_valid;
  logic [CH_W-1:0] norm_res_chan;
  fix_t            norm_value;

  nlc_param_store #(
    .NUM_CH (NUM_CH)
  ) u_store (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .load_chan   (load_chan),
    .load_params (load_params),
    .norm_chan   (norm_rd_chan),
    .norm_params (norm_params),
    .poly_chan   (poly_rd_chan),
    .poly_params (poly_params)
  );

  nlc_normalizer #(
    .NUM_CH (NUM_CH)
  ) u_norm (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .chan       (norm_rd_chan),
    .params     (norm_params),
    .req_valid  (norm_req_valid),
    .req        (norm_req),
    .gnt        (norm_gnt),
    .rsp_valid  (norm_rsp_valid),
    .rsp_result (rsp_result),
    .norm_valid (norm_valid),
    .norm_chan  (norm_res_chan),
    .norm_value (norm_value)
  );

  nlc_poly_engine #(
    .NUM_CH (NUM_CH)
  ) u_poly (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .norm_valid (norm_valid),
    .norm_chan  (norm_res_chan),
    .norm_value (norm_value),
    .chan       (poly_rd_chan),
    .params     (poly_params),
    .req_valid  (poly_req_valid),
    .req        (poly_req),
    .gnt        (poly_gnt),
    .rsp_valid  (poly_rsp_valid),
    .rsp_result (rsp_result),
    .out_valid  (out_valid),
    .out_chan   (out_chan),
    .out_value  (out_value),
    .done       (done)
  );

  nlc_arbiter u_arb (
    .norm_req_valid (norm_req_valid),
    .norm_req       (norm_req),
    .norm_gnt       (norm_gnt),
    .norm_rsp_valid (norm_rsp_valid),
    .poly_req_valid (poly_req_valid),
    .poly_req       (poly_req),
    .poly_gnt       (poly_gnt),
    .poly_rsp_valid (poly_rsp_valid),
    .rsp_result     (rsp_result),
    .unit_req_valid (unit_req_valid),
    .unit_req       (unit_req),
    .unit_rsp_valid (unit_rsp_valid),
    .unit_rsp       (unit_rsp)
  );

  nlc_arith_unit #(
    .ARITH_LATENCY (ARITH_LATENCY)
  ) u_arith (
    .clk       (clk),
    .rst       (rst),
    .req_valid (unit_req_valid),
    .req       (unit_req),
    .rsp_valid (unit_rsp_valid),
    .rsp       (unit_rsp)
  );

endmodule

//--- test/nlc_tb_model.svh
`ifndef NLC_TB_MODEL_SVH
`define NLC_TB_MODEL_SVH

// Q16.16 add, wraps to the word width
function automatic fix_t model_add(fix_t a, fix_t b);
  return fix_t'(longint'(a) + longint'(b));
endfunction

// Full product, fraction bits dropped, low word kept
function automatic fix_t model_mul(fix_t a, fix_t b);
  longint p;
  p = longint'(a) * longint'(b);
  return fix_t'(p >>> FRAC_BITS);
endfunction

function automatic fix_t sample_to_fix(sample_t s);
  return fix_t'(longint'(s) <<< FRAC_BITS);
endfunction

// Floor to an integer sample
function automatic sample_t fix_floor(fix_t v);
  return sample_t'(longint'(v) >>> FRAC_BITS);
endfunction

// Normalize, then Horner from the leading coefficient down
function automatic sample_t expected_output(chan_params_t p);
  fix_t x;
  fix_t acc;
  x   = model_mul(model_add(sample_to_fix(p.sample), p.neg_mean), p.recip_stdev);
  acc = p.coeff[POLY_ORDER];
  for (int k = POLY_ORDER - 1; k >= 0; k--) begin
    acc = model_add(model_mul(acc, x), p.coeff[k]);
  end
  return fix_floor(acc);
endfunction

// Results of the current run, by channel
sample_t got_value [NUM_CH];
int      got_count [NUM_CH];

function automatic void clear_results();
  for (int c = 0; c < NUM_CH; c++) begin
    got_count[c] = 0;
    got_value[c] = '0;
  end
endfunction

function automatic void record_result(int c, sample_t v);
  got_count[c]++;
  got_value[c] = v;
endfunction

`endif

//--- test/nlc_tb.sv
module nlc_tb;
  timeunit 1ns;
  timeprecision 1ns;

  import nlc_fix_pkg::*;
  import nlc_chan_pkg::*;

  localparam int NUM_CH         = 16;
  localparam int ARITH_LATENCY  = 2;
  localparam int CH_W           = $clog2(NUM_CH);
  localparam int NUM_RUNS       = 6;
  localparam int TIMEOUT_CYCLES = NUM_RUNS * NUM_CH * 10 * (ARITH_LATENCY + 2) + 200;
  // Long enough for a restarted normalizer pass to drain
  localparam int IDLE_CYCLES    = NUM_CH * 2 * (ARITH_LATENCY + 1) + 20;

  logic            clk;
  logic            rst;
  logic            load;
  logic [CH_W-1:0] load_chan;
  chan_params_t    load_params;
  logic            start;
  logic            out_valid;
  logic [CH_W-1:0] out_chan;
  sample_t         out_value;
  logic            done;

  integer       seed;
  int           cycle_count = 0;
  int           error_count;
  int           tests_run;
  int           tests_failed;
  int           test_start_errors;
  chan_params_t loaded [NUM_CH];
  sample_t      prev_value [NUM_CH];

  `include "nlc_tb_model.svh"

  nlc_controller #(
    .NUM_CH        (NUM_CH),
    .ARITH_LATENCY (ARITH_LATENCY)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .load_chan   (load_chan),
    .load_params (load_params),
    .start       (start),
    .out_valid   (out_valid),
    .out_chan    (out_chan),
    .out_value   (out_value),
    .done        (done)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic note_error(string msg);
    $display("%0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_value(string what, int c, sample_t exp, sample_t got);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s channel %0d expected %0d got %0d", $time, what, c, exp, got);
      error_count++;
    end
  endtask

  function automatic chan_params_t random_params();
    chan_params_t p;
    p.sample      = sample_t'($random(seed) % 4096);
    p.neg_mean    = fix_t'($random(seed) % (4 << FRAC_BITS));
    p.recip_stdev = fix_t'($random(seed) % (4 << FRAC_BITS));
    for (int k = 0; k <= POLY_ORDER; k++) begin
      p.coeff[k] = fix_t'($random(seed) % (1 << (FRAC_BITS - 1)));
    end
    return p;
  endfunction

  task automatic load_channel(int c, chan_params_t p);
    load        = 1'b1;
    load_chan   = CH_W'(c);
    load_params = p;
    loaded[c]   = p;
    @(negedge clk);
    load = 1'b0;
  endtask

  // Pulse start and collect results until done with optional starts mid-run
  task automatic run_engine(bit busy_starts);
    int cycle;
    int next_chan;
    bit seen_done;
    clear_results();
    cycle     = 0;
    next_chan = 0;
    seen_done = 1'b0;
    start     = 1'b1;
    @(negedge clk);
    while (!seen_done) begin
      start = 1'b0;
      if (out_valid) begin
        if (int'(out_chan) != next_chan) begin
          note_error($sformatf("result for channel %0d arrived, channel %0d was next",
                               out_chan, next_chan));
        end
        if (done != (int'(out_chan) == NUM_CH - 1)) begin
          note_error($sformatf("done was %0b with the result of channel %0d", done, out_chan));
        end
        record_result(int'(out_chan), out_value);
        next_chan++;
        if (busy_starts && next_chan == NUM_CH / 2) begin
          start = 1'b1;
        end
      end else if (done) begin
        note_error("done rose without a result");
      end
      if (busy_starts && cycle == 3) begin
        start = 1'b1;
      end
      seen_done = done;
      cycle++;
      @(negedge clk);
    end
    start = 1'b0;
  endtask

  task automatic check_stream();
    for (int c = 0; c < NUM_CH; c++) begin
      if (got_count[c] != 1) begin
        note_error($sformatf("channel %0d gave %0d results instead of one", c, got_count[c]));
      end
    end
  endtask

  task automatic check_against_model(string what);
    for (int c = 0; c < NUM_CH; c++) begin
      check_value(what, c, expected_output(loaded[c]), got_value[c]);
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (error_count == test_start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, error_count - test_start_errors);
    end
  endtask

  task automatic test_identity();
    chan_params_t p;
    test_start_errors = error_count;
    for (int c = 0; c < NUM_CH; c++) begin
      p             = '0;
      p.recip_stdev = fix_t'(1 << FRAC_BITS);
      p.coeff[1]    = fix_t'(1 << FRAC_BITS);
      if (c == 0) begin
        p.sample = sample_t'(-32768);
      end else if (c == 1) begin
        p.sample = sample_t'(32767);
      end else if (c % 2 == 1) begin
        p.sample = sample_t'(-(c * 1000 + 7));
      end else begin
        p.sample = sample_t'(c * 1000 + 3);
      end
      load_channel(c, p);
    end
    run_engine(1'b0);
    check_stream();
    for (int c = 0; c < NUM_CH; c++) begin
      check_value("identity", c, loaded[c].sample, got_value[c]);
    end
    end_test("identity");
  endtask

  task automatic test_constant();
    chan_params_t p;
    test_start_errors = error_count;
    for (int c = 0; c < NUM_CH; c++) begin
      p = random_params();
      for (int k = 1; k <= POLY_ORDER; k++) begin
        p.coeff[k] = '0;
      end
      p.coeff[0] = fix_t'($random(seed) % (1000 << FRAC_BITS));
      load_channel(c, p);
    end
    run_engine(1'b0);
    check_stream();
    check_against_model("constant");
    end_test("constant correction");
  endtask

  task automatic test_random();
    test_start_errors = error_count;
    for (int c = 0; c < NUM_CH; c++) begin
      load_channel(c, random_params());
    end
    run_engine(1'b0);
    check_stream();
    check_against_model("random");
    end_test("random full run");
  endtask

  task automatic test_busy_start();
    int extra;
    int drops;
    test_start_errors = error_count;
    extra = 0;
    drops = 0;
    run_engine(1'b1);
    check_stream();
    check_against_model("busy start");
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      if (out_valid) begin
        extra++;
      end
      if (!done) begin
        drops++;
      end
      @(negedge clk);
    end
    if (extra != 0) begin
      note_error($sformatf("%0d results came out after done", extra));
    end
    if (drops != 0) begin
      note_error($sformatf("done was low for %0d cycles after the run", drops));
    end
    end_test("start while busy");
  endtask

  task automatic test_reload();
    chan_params_t p;
    int           ch;
    test_start_errors = error_count;
    run_engine(1'b0);
    check_stream();
    check_against_model("reload baseline");
    for (int c = 0; c < NUM_CH; c++) begin
      prev_value[c] = expected_output(loaded[c]);
    end
    ch = ($random(seed) & 32'h7fff_ffff) % NUM_CH;
    p  = random_params();
    // A new record with the same result would prove nothing
    for (int i = 0; i < 8 && expected_output(p) == prev_value[ch]; i++) begin
      p = random_params();
    end
    load_channel(ch, p);
    run_engine(1'b0);
    check_stream();
    for (int c = 0; c < NUM_CH; c++) begin
      if (c == ch) begin
        check_value("reloaded", c, expected_output(p), got_value[c]);
      end else begin
        check_value("unchanged", c, prev_value[c], got_value[c]);
      end
    end
    end_test("single-channel reload");
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    load         = 1'b0;
    load_chan    = '0;
    load_params  = '0;
    start        = 1'b0;
    seed         = 2;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    test_identity();
    test_constant();
    test_random();
    test_busy_start();
    test_reload();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+test
verilog/nlc_fix_pkg.sv
verilog/nlc_chan_pkg.sv
verilog/nlc_param_store.sv
verilog/nlc_arith_unit.sv
verilog/nlc_arbiter.sv
verilog/nlc_normalizer.sv
verilog/nlc_poly_engine.sv
verilog/nlc_controller.sv
test/nlc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nlc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard test/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
